// ==== Makefile ====
# Verilator build and run for the convolution engine testbench

VERILATOR ?= verilator
TOP ?= convolveTb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_TEXT ?= Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== project.f ====
+incdir+tests
verilog/convPkg.sv
verilog/scratchMemory.sv
verilog/macUnit.sv
verilog/shiftUnit.sv
verilog/convolve.sv
verilog/convolveTop.sv
tests/convolveTb.sv

// ==== tests/refModel.svh ====
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

////////////////////
// Reference arithmetic
////////////////////

// Clamp to the Q31 range
function automatic accum clampQ31(input longint v);
	if (v > 64'sd2147483647)
		return 32'sh7fff_ffff;
	if (v < -64'sd2147483648)
		return 32'sh8000_0000;
	return accum'(v);
endfunction

// Doubled product, saturated
function automatic accum doubledProduct(input sample a, input sample b);
	return clampQ31(2 * longint'(a) * longint'(b));
endfunction

function automatic accum saturatingAdd(input accum a, input accum b);
	return clampQ31(longint'(a) + longint'(b));
endfunction

// Whole scaling shift at once, then saturate
function automatic accum scaleUp(input accum v);
	return clampQ31(longint'(v) * (64'sd1 <<< scaleShift));
endfunction

// One output sample as the high half after scaling
function automatic sample modelOutput(
	input sample x [convLength],
	input sample h [convLength],
	input int n
);
	accum acc;
	acc = '0;
	for (int i = 0; i <= n; i++)
		acc = saturatingAdd(acc, doubledProduct(x[i], h[n - i]));
	acc = scaleUp(acc);
	return acc[31:16];
endfunction

`endif

// ==== tests/convolveTb.sv ====
`timescale 1ns/10ps

module convolveTb import convPkg::*; ();

	// One run has row setup, three cycles per term, scaling and store
	localparam int runCycles = convLength * (3 + scaleShift)
		+ 3 * convLength * (convLength + 1) / 2;
	// Twice the time of four runs plus the load and read phases
	localparam int timeoutCycles = 2 * (4 * runCycles + 2000);

	localparam convConfig cfgA = '{xBase: 8'd0, hBase: 8'd40, yBase: 8'd80};
	localparam convConfig cfgB = '{xBase: 8'd120, hBase: 8'd160, yBase: 8'd200};
	// Data of run A with results aimed at the run B outputs
	localparam convConfig cfgStray = '{xBase: 8'd0, hBase: 8'd40, yBase: 8'd200};

	logic clk;
	logic reset;
	hostReq host;
	sample readData;
	logic readValid;
	convConfig cfg;
	logic start;
	logic busy;
	logic done;
	logic prevBusy;

	sample xVec [convLength];
	sample hVec [convLength];
	sample yExpA [convLength];
	sample yExpB [convLength];

	`include "refModel.svh"

	convolveTop i_convolveTop (
		.clk(clk),
		.reset(reset),
		.host(host),
		.readData(readData),
		.readValid(readValid),
		.cfg(cfg),
		.start(start),
		.busy(busy),
		.done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string testName, input sample expected, input sample actual);
		assert (actual === expected)
		else
			reportFailure($sformatf("FAIL %s expected %h actual %h",
				testName, expected, actual));
	endtask

	task automatic writeWord(input memAddr addr, input sample data);
		host.writeEn = 1'b1;
		host.addr = addr;
		host.data = data;
		@(negedge clk);
		host.writeEn = 1'b0;
	endtask

	// Data comes back one cycle after the strobe
	task automatic readWord(input memAddr addr, output sample value);
		host.readEn = 1'b1;
		host.addr = addr;
		@(negedge clk);
		host.readEn = 1'b0;
		assert (readValid)
		else
			reportFailure("host read got no readValid while the engine was idle");
		value = readData;
	endtask

	task automatic fillRandom(input int span);
		for (int k = 0; k < convLength; k++)
		begin
			xVec[k] = sample'($urandom_range(0, span - 1) - span / 2);
			hVec[k] = sample'($urandom_range(0, span - 1) - span / 2);
		end
	endtask

	task automatic computeExpected(output sample yExp [convLength]);
		for (int n = 0; n < convLength; n++)
			yExp[n] = modelOutput(xVec, hVec, n);
	endtask

	task automatic loadVectors(input convConfig c);
		for (int k = 0; k < convLength; k++)
		begin
			writeWord(c.xBase + memAddr'(k), xVec[k]);
			writeWord(c.hBase + memAddr'(k), hVec[k]);
		end
	endtask

	task automatic startRun(input convConfig c);
		cfg = c;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic waitDone();
		while (!done)
			@(negedge clk);
	endtask

	task automatic checkResults(input string testName, input memAddr base,
		input sample yExp [convLength]);
		sample value;
		for (int n = 0; n < convLength; n++)
		begin
			readWord(base + memAddr'(n), value);
			checkValue($sformatf("%s y[%0d]", testName, n), yExp[n], value);
		end
	endtask

	////////////////////
	// Protocol checks
	////////////////////

	assert property (@(posedge clk) disable iff (reset) (start && !busy) |=> busy)
	else
		reportFailure("busy did not rise the cycle after an accepted start");

	// Strobe and lockout relations from one cycle to the next
	always @(negedge clk)
	begin
		if (reset)
			prevBusy = 1'b0;
		else
		begin
			assert (done == (prevBusy && !busy))
			else
				reportFailure("done did not pulse exactly when busy fell");
			assert (!(prevBusy && readValid))
			else
				reportFailure("host read returned readValid while the engine was busy");
			prevBusy = busy;
		end
	end

	initial
	begin
		repeat (timeoutCycles) @(posedge clk);
		reportFailure("watchdog expired before the tests finished");
	end

	////////////////////
	// Stimulus
	////////////////////

	initial
	begin
		void'($urandom(32'h5e84));
		reset = 1'b1;
		host = '0;
		cfg = '0;
		start = 1'b0;
		repeat (2) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		assert (!busy && !done && !readValid)
		else
			reportFailure("busy, done or readValid is high after reset");

		// Small samples keep most sums out of saturation
		fillRandom(4096);
		computeExpected(yExpA);
		loadVectors(cfgA);
		startRun(cfgA);
		waitDone();
		checkResults("random", cfgA.yBase, yExpA);

		// Full range data at other bases
		fillRandom(65536);
		computeExpected(yExpB);
		loadVectors(cfgB);
		startRun(cfgB);
		waitDone();
		checkResults("relocated", cfgB.yBase, yExpB);
		checkResults("relocatedOldOutputs", cfgA.yBase, yExpA);

		// Min times min everywhere clamps all outputs high
		for (int k = 0; k < convLength; k++)
		begin
			xVec[k] = 16'sh8000;
			hVec[k] = 16'sh8000;
			yExpA[k] = 16'sh7fff;
		end
		loadVectors(cfgA);
		startRun(cfgA);
		waitDone();
		checkResults("saturation", cfgA.yBase, yExpA);

		// Host traffic and a second start in the middle of a run
		fillRandom(4096);
		computeExpected(yExpA);
		loadVectors(cfgA);
		startRun(cfgA);
		repeat (20) @(negedge clk);
		for (int k = 0; k < convLength; k++)
			writeWord(cfgA.xBase + memAddr'(k), sample'($urandom));
		host.readEn = 1'b1;
		repeat (4) @(negedge clk);
		host.readEn = 1'b0;
		startRun(cfgStray);
		waitDone();
		repeat (100)
		begin
			@(negedge clk);
			assert (!busy && !done)
			else
				reportFailure("a start during the run began a second run");
		end
		checkResults("lockout", cfgA.yBase, yExpA);
		checkResults("startWhileBusy", cfgB.yBase, yExpB);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== verilog/convPkg.sv ====
package convPkg;

	////////////////////
	// Sizes
	////////////////////

	// Output samples per run
	localparam int convLength = 40;
	localparam int addrWidth = 8;
	localparam int memDepth = 256;
	// Left shift before the high half is taken
	localparam int scaleShift = 3;
	// Wide enough for the row and term counters
	localparam int countWidth = $clog2(convLength);

	// Saturation limits, Q15 and Q31
	localparam logic signed [15:0] sampleMin = 16'sh8000;
	localparam logic signed [31:0] accumMax = 32'sh7fff_ffff;
	localparam logic signed [31:0] accumMin = 32'sh8000_0000;

	////////////////////
	// Types
	////////////////////

	typedef logic [addrWidth-1:0] memAddr;
	typedef logic signed [15:0] sample;
	typedef logic signed [31:0] accum;

	// One host access, strobes last a single cycle
	typedef struct packed {
		logic writeEn;
		logic readEn;
		memAddr addr;
		sample data;
	} hostReq;

	// Vector base addresses
	typedef struct packed {
		memAddr xBase;
		memAddr hBase;
		memAddr yBase;
	} convConfig;

	typedef struct packed {
		logic writeEn;
		memAddr addr;
		sample data;
	} engineReq;

	typedef enum logic [2:0] {
		idle,
		nextRow,
		fetchX,
		fetchH,
		accumulate,
		scaleStart,
		scaleWait,
		store
	} convState;

endpackage

// ==== verilog/convolve.sv ====
`timescale 1ns/10ps

module convolve import convPkg::*; (
	input logic clk,
	input logic reset,
	input logic start,
	input convConfig cfg,
	output logic busy,
	output logic done,
	output engineReq engine,
	input sample memData,
	output accum macAcc,
	output sample macA,
	output sample macB,
	input accum macSum,
	output logic shiftStart,
	output accum shiftOperand,
	output logic [3:0] shiftCount,
	input accum shiftResult,
	input logic shiftDone
);

	convState state;
	logic [countWidth-1:0] n;
	logic [countWidth-1:0] i;
	accum acc;
	sample xSample;
	convConfig cfgReg;

	////////////////////
	// Arithmetic hookup
	////////////////////

	// x was latched in fetchH, h arrives from memory in accumulate
	assign macAcc = acc;
	assign macA = xSample;
	assign macB = memData;

	assign shiftStart = state == scaleStart;
	assign shiftOperand = acc;
	assign shiftCount = 4'(scaleShift);

	////////////////////
	// Memory requests
	////////////////////

	always_comb
	begin
		engine = '0;
		case (state)
			fetchX:
				engine.addr = cfgReg.xBase + memAddr'(i);
			// n is never below i, so the difference stays positive
			fetchH:
				engine.addr = cfgReg.hBase + memAddr'(n - i);
			store:
			begin
				engine.writeEn = 1'b1;
				engine.addr = cfgReg.yBase + memAddr'(n);
				engine.data = acc[31:16];
			end
			default:
				engine = '0;
		endcase
	end

	////////////////////
	// Sequencer
	////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= idle;
			busy <= 1'b0;
			done <= 1'b0;
			n <= '0;
			i <= '0;
			acc <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				idle:
					if (start)
					begin
						busy <= 1'b1;
						n <= '0;
						state <= nextRow;
					end
				nextRow:
				begin
					acc <= '0;
					i <= '0;
					state <= fetchX;
				end
				fetchX:
					state <= fetchH;
				fetchH:
					state <= accumulate;
				accumulate:
				begin
					acc <= macSum;
					if (i == n)
						state <= scaleStart;
					else
					begin
						i <= i + 1'b1;
						state <= fetchX;
					end
				end
				scaleStart:
					state <= scaleWait;
				scaleWait:
					if (shiftDone)
					begin
						acc <= shiftResult;
						state <= store;
					end
				// Last row ends the run, done and busy change together
				store:
					if (n == countWidth'(convLength - 1))
					begin
						done <= 1'b1;
						busy <= 1'b0;
						state <= idle;
					end
					else
					begin
						n <= n + 1'b1;
						state <= nextRow;
					end
				default:
					state <= idle;
			endcase
		end
	end

	// Payload latches
	always_ff @(posedge clk)
	begin
		if (state == idle && start)
			cfgReg <= cfg;
		if (state == fetchH)
			xSample <= memData;
	end

endmodule

// ==== verilog/convolveTop.sv ====
`timescale 1ns/10ps

module convolveTop import convPkg::*; (
	input logic clk,
	input logic reset,
	input hostReq host,
	output sample readData,
	output logic readValid,
	input convConfig cfg,
	input logic start,
	output logic busy,
	output logic done
);

	engineReq engine;
	accum macAcc;
	sample macA;
	sample macB;
	accum macSum;
	logic shiftStart;
	accum shiftOperand;
	logic [3:0] shiftCount;
	accum shiftResult;
	logic shiftDone;

	// Host and engine share one registered read port
	scratchMemory i_scratchMemory (
		.clk(clk),
		.reset(reset),
		.busy(busy),
		.host(host),
		.engine(engine),
		.readData(readData),
		.readValid(readValid)
	);

	convolve i_convolve (
		.clk(clk),
		.reset(reset),
		.start(start),
		.cfg(cfg),
		.busy(busy),
		.done(done),
		.engine(engine),
		.memData(readData),
		.macAcc(macAcc),
		.macA(macA),
		.macB(macB),
		.macSum(macSum),
		.shiftStart(shiftStart),
		.shiftOperand(shiftOperand),
		.shiftCount(shiftCount),
		.shiftResult(shiftResult),
		.shiftDone(shiftDone)
	);

	macUnit i_macUnit (
		.acc(macAcc),
		.a(macA),
		.b(macB),
		.sum(macSum)
	);

	shiftUnit i_shiftUnit (
		.clk(clk),
		.reset(reset),
		.shiftStart(shiftStart),
		.operand(shiftOperand),
		.count(shiftCount),
		.result(shiftResult),
		.shiftDone(shiftDone)
	);

endmodule

// ==== verilog/macUnit.sv ====
`timescale 1ns/10ps

module macUnit import convPkg::*; (
	input accum acc,
	input sample a,
	input sample b,
	output accum sum
);

	accum rawProduct;
	accum product;
	logic signed [32:0] wideSum;

	////////////////////
	// Doubled product
	////////////////////

	// Full 32-bit signed product of the two Q15 words
	always_comb
	begin
		rawProduct = a * b;
	end

	// Only min times min overflows when doubled
	always_comb
	begin
		if (a == sampleMin && b == sampleMin)
			product = accumMax;
		else
			product = rawProduct <<< 1;
	end

	////////////////////
	// Saturating add
	////////////////////

	always_comb
	begin
		wideSum = {acc[31], acc} + {product[31], product};
	end

	// Top two bits differ on overflow, bit 32 holds the true sign
	always_comb
	begin
		if (wideSum[32] != wideSum[31])
		begin
			if (wideSum[32])
				sum = accumMin;
			else
				sum = accumMax;
		end
		else
			sum = wideSum[31:0];
	end

endmodule

// ==== verilog/scratchMemory.sv ====
`timescale 1ns/10ps

module scratchMemory import convPkg::*; (
	input logic clk,
	input logic reset,
	input logic busy,
	input hostReq host,
	input engineReq engine,
	output sample readData,
	output logic readValid
);

	sample mem [memDepth];

	memAddr addr;
	logic writeEn;
	sample writeData;

	// Engine owns the array for the whole run
	always_comb
	begin
		if (busy)
		begin
			addr = engine.addr;
			writeEn = engine.writeEn;
			writeData = engine.data;
		end
		else
		begin
			addr = host.addr;
			writeEn = host.writeEn;
			writeData = host.data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (writeEn)
			mem[addr] <= writeData;
		readData <= mem[addr];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			readValid <= 1'b0;
		else
			readValid <= host.readEn && !busy;
	end

endmodule

// ==== verilog/shiftUnit.sv ====
`timescale 1ns/10ps

module shiftUnit import convPkg::*; (
	input logic clk,
	input logic reset,
	input logic shiftStart,
	input accum operand,
	input logic [3:0] count,
	output accum result,
	output logic shiftDone
);

	accum value;
	logic [3:0] remaining;
	logic running;

	// One saturating shift step. Sign matches the original
	// value until the first clamp, and a clamped value stays put
	function automatic accum shiftStep(input accum v);
		if (v[31] != v[30])
			return v[31] ? accumMin : accumMax;
		return v <<< 1;
	endfunction

	assign result = value;

	// First step happens on the loading edge
	always_ff @(posedge clk)
	begin
		if (shiftStart && !running)
		begin
			if (count == 4'd0)
				value <= operand;
			else
				value <= shiftStep(operand);
		end
		else if (running)
			value <= shiftStep(value);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			remaining <= 4'd0;
			shiftDone <= 1'b0;
		end
		else if (shiftStart && !running)
		begin
			running <= count > 4'd1;
			remaining <= (count == 4'd0) ? 4'd0 : count - 4'd1;
			shiftDone <= count <= 4'd1;
		end
		else if (running)
		begin
			remaining <= remaining - 4'd1;
			shiftDone <= remaining == 4'd1;
			running <= remaining != 4'd1;
		end
		else
			shiftDone <= 1'b0;
	end

endmodule
